// File: design/ptw_pkg.sv
`default_nettype none

package ptw_pkg;

    // ##################################################
    // Sv32 widths
    // ##################################################

    localparam int VADDR_W  = 32;
    localparam int PADDR_W  = 34;
    localparam int VPN_W    = 10;
    localparam int OFFSET_W = 12;
    localparam int PPN_W    = 22;
    localparam int PTE_W    = 32;

    // ##################################################
    // Page table entry and walk types
    // ##################################################

    // Field order matches the Sv32 bit layout, v in bit 0
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    typedef enum logic [1:0] {
        ACC_LOAD  = 2'd0,
        ACC_STORE = 2'd1,
        ACC_FETCH = 2'd2
    } access_t;

    // Level 1 is the root table
    typedef enum logic {
        LEVEL_0 = 1'b0,
        LEVEL_1 = 1'b1
    } level_t;

endpackage

`default_nettype wire

// File: design/ptw_req_queue.sv
`default_nettype none

module ptw_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       push,
    input  logic [ptw_pkg::VADDR_W-1:0] push_vaddr,
    input  ptw_pkg::access_t           push_access,
    input  logic                       pop,
    output logic                       full,
    output logic                       head_valid,
    output logic [ptw_pkg::VADDR_W-1:0] head_vaddr,
    output ptw_pkg::access_t           head_access
);
    import ptw_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [VADDR_W-1:0] vaddr_mem [QUEUE_DEPTH];
    access_t            access_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    assign full       = (count == QUEUE_DEPTH[PTR_W:0]);
    assign head_valid = (count != '0);
    assign do_push    = push && !full;
    assign do_pop     = pop && head_valid;

    assign head_vaddr  = vaddr_mem[rd_ptr];
    assign head_access = access_mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            vaddr_mem[wr_ptr]  <= push_vaddr;
            access_mem[wr_ptr] <= push_access;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/ptw_walker.sv
`default_nettype none

module ptw_walker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic [ptw_pkg::PPN_W-1:0]   satp_ppn,
    input  logic                        head_valid,
    input  logic [ptw_pkg::VADDR_W-1:0] head_vaddr,
    input  ptw_pkg::access_t            head_access,
    input  logic                        mem_rvalid,
    input  ptw_pkg::pte_t               mem_rdata,
    input  logic                        descend,
    input  logic                        resp_taken,
    output logic                        pop,
    output logic                        mem_rd,
    output logic [ptw_pkg::PADDR_W-1:0] mem_addr,
    output logic                        pte_strobe,
    output ptw_pkg::pte_t               pte,
    output ptw_pkg::level_t             walk_level,
    output logic [ptw_pkg::VADDR_W-1:0] walk_vaddr,
    output ptw_pkg::access_t            walk_access
);
    import ptw_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_HOLD
    } state_t;

    state_t           state;
    logic             walk_abort;
    logic [PPN_W-1:0] table_ppn;
    logic [VPN_W-1:0] vpn_sel;

    // ##################################################
    // Outputs
    // ##################################################

    assign pop    = (state == ST_IDLE) && head_valid && !flush;
    assign mem_rd = (state == ST_READ);

    assign vpn_sel = (walk_level == LEVEL_1) ? walk_vaddr[VADDR_W-1 -: VPN_W]
                                             : walk_vaddr[OFFSET_W +: VPN_W];

    // Table page, then the index into it, word aligned
    assign mem_addr = {table_ppn, vpn_sel, 2'b00};

    // Entry goes to the checker in the same cycle it arrives
    assign pte_strobe = (state == ST_WAIT) && mem_rvalid && !walk_abort && !flush;
    assign pte        = mem_rdata;

    // ##################################################
    // Walk FSM
    // ##################################################

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= ST_IDLE;
            walk_abort <= 1'b0;
            walk_level <= LEVEL_1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state      <= ST_READ;
                        walk_level <= LEVEL_1;
                    end
                end
                ST_READ: begin
                    // The read is already out, so a flush has to wait for its data
                    state <= ST_WAIT;
                    if (flush) begin
                        walk_abort <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (mem_rvalid) begin
                        if (walk_abort || flush) begin
                            state      <= ST_IDLE;
                            walk_abort <= 1'b0;
                        end else if (descend) begin
                            state      <= ST_READ;
                            walk_level <= LEVEL_0;
                        end else begin
                            state <= ST_HOLD;
                        end
                    end else if (flush) begin
                        walk_abort <= 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (flush || resp_taken) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request fields and the current table page
    always_ff @(posedge clk) begin
        if (pop) begin
            walk_vaddr  <= head_vaddr;
            walk_access <= head_access;
            table_ppn   <= satp_ppn;
        end else if (pte_strobe && descend) begin
            table_ppn <= mem_rdata.ppn;
        end
    end

endmodule

`default_nettype wire

// File: design/ptw_pte_check.sv
`default_nettype none

module ptw_pte_check (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        pte_strobe,
    input  ptw_pkg::pte_t               pte,
    input  ptw_pkg::level_t             walk_level,
    input  logic [ptw_pkg::VADDR_W-1:0] walk_vaddr,
    input  ptw_pkg::access_t            walk_access,
    input  logic                        resp_ready,
    output logic                        descend,
    output logic                        resp_taken,
    output logic                        resp_valid,
    output logic [ptw_pkg::VADDR_W-1:0] resp_vaddr,
    output ptw_pkg::pte_t               resp_pte,
    output ptw_pkg::level_t             resp_level,
    output logic                        resp_fault
);
    import ptw_pkg::*;

    logic is_leaf;
    logic perm_fault;
    logic misaligned;
    logic fault;
    logic load_resp;

    assign is_leaf = pte.r || pte.w || pte.x;

    // Pointer to the next table, only possible from the root
    assign descend = pte_strobe && pte.v && !is_leaf && (walk_level == LEVEL_1);

    // ##################################################
    // Fault rules
    // ##################################################

    // Superpage must be 4 MiB aligned
    assign misaligned = is_leaf && (walk_level == LEVEL_1) && (pte.ppn[VPN_W-1:0] != '0);

    always_comb begin
        case (walk_access)
            ACC_LOAD:  perm_fault = !pte.r;
            ACC_STORE: perm_fault = !pte.w || !pte.d;
            ACC_FETCH: perm_fault = !pte.x;
            default:   perm_fault = 1'b1;
        endcase
    end

    assign fault = !pte.v
                || (pte.w && !pte.r)
                || (!is_leaf && (walk_level == LEVEL_0))
                || misaligned
                || perm_fault
                || !pte.a;

    // ##################################################
    // Response register
    // ##################################################

    assign load_resp  = pte_strobe && !descend;
    assign resp_taken = resp_valid && resp_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            resp_valid <= 1'b0;
        end else if (flush) begin
            resp_valid <= 1'b0;
        end else if (load_resp) begin
            resp_valid <= 1'b1;
        end else if (resp_taken) begin
            resp_valid <= 1'b0;
        end
    end

    // Held stable until taken, the walker starts nothing new meanwhile
    always_ff @(posedge clk) begin
        if (load_resp) begin
            resp_vaddr <= walk_vaddr;
            resp_pte   <= pte;
            resp_level <= walk_level;
            resp_fault <= fault;
        end
    end

endmodule

`default_nettype wire

// File: design/ptw_top.sv
`default_nettype none

module ptw_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        req_valid,
    input  logic [ptw_pkg::VADDR_W-1:0] req_vaddr,
    input  ptw_pkg::access_t            req_access,
    output logic                        req_full,

    input  logic [ptw_pkg::PPN_W-1:0]   satp_ppn,
    input  logic                        flush,

    output logic                        mem_rd,
    output logic [ptw_pkg::PADDR_W-1:0] mem_addr,
    input  logic                        mem_rvalid,
    input  ptw_pkg::pte_t               mem_rdata,

    output logic                        resp_valid,
    input  logic                        resp_ready,
    output logic [ptw_pkg::VADDR_W-1:0] resp_vaddr,
    output ptw_pkg::pte_t               resp_pte,
    output ptw_pkg::level_t             resp_level,
    output logic                        resp_fault
);
    import ptw_pkg::*;

    logic               push;
    logic               pop;
    logic               head_valid;
    logic [VADDR_W-1:0] head_vaddr;
    access_t            head_access;

    // Walker to checker
    logic               pte_strobe;
    pte_t               pte;
    level_t             walk_level;
    logic [VADDR_W-1:0] walk_vaddr;
    access_t            walk_access;
    logic               descend;
    logic               resp_taken;

    // Offers while full are dropped here
    assign push = req_valid && !req_full;

    ptw_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_ptw_req_queue (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .push        (push),
        .push_vaddr  (req_vaddr),
        .push_access (req_access),
        .pop         (pop),
        .full        (req_full),
        .head_valid  (head_valid),
        .head_vaddr  (head_vaddr),
        .head_access (head_access)
    );

    ptw_walker i_ptw_walker (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .satp_ppn    (satp_ppn),
        .head_valid  (head_valid),
        .head_vaddr  (head_vaddr),
        .head_access (head_access),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .descend     (descend),
        .resp_taken  (resp_taken),
        .pop         (pop),
        .mem_rd      (mem_rd),
        .mem_addr    (mem_addr),
        .pte_strobe  (pte_strobe),
        .pte         (pte),
        .walk_level  (walk_level),
        .walk_vaddr  (walk_vaddr),
        .walk_access (walk_access)
    );

    ptw_pte_check i_ptw_pte_check (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .pte_strobe  (pte_strobe),
        .pte         (pte),
        .walk_level  (walk_level),
        .walk_vaddr  (walk_vaddr),
        .walk_access (walk_access),
        .resp_ready  (resp_ready),
        .descend     (descend),
        .resp_taken  (resp_taken),
        .resp_valid  (resp_valid),
        .resp_vaddr  (resp_vaddr),
        .resp_pte    (resp_pte),
        .resp_level  (resp_level),
        .resp_fault  (resp_fault)
    );

endmodule

`default_nettype wire

// File: tests/tb_ptw_top.sv
`default_nettype none

module tb_ptw_top;
    import ptw_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic [VADDR_W-1:0] req_vaddr;
    access_t            req_access;
    logic               req_full;
    logic [PPN_W-1:0]   satp_ppn;
    logic               flush;
    logic               mem_rd;
    logic [PADDR_W-1:0] mem_addr;
    logic               mem_rvalid;
    pte_t               mem_rdata;
    logic               resp_valid;
    logic               resp_ready;
    logic [VADDR_W-1:0] resp_vaddr;
    pte_t               resp_pte;
    level_t             resp_level;
    logic               resp_fault;

    // Word addressed memory image with zero for missing words
    logic [PTE_W-1:0]   mem [logic [31:0]];

    // Requests waiting for a walk and responses still owed
    logic [VADDR_W-1:0] walk_q [$];
    logic [VADDR_W-1:0] exp_vaddr [$];
    level_t             exp_level [$];
    pte_t               exp_pte [$];
    logic               exp_fault [$];

    int errors;
    int checks;
    int rd_count;
    bit timed_out;
    bit full_seen;

    // Walk tracking for the address check
    bit                 in_flight;
    bit                 aborted;
    bit                 expect_l0;
    logic [PPN_W-1:0]   next_ppn;
    logic [VADDR_W-1:0] cur_vaddr;
    level_t             cur_level;

    // Previous cycle of the response port
    bit                 prev_hold;
    logic [VADDR_W-1:0] held_vaddr;
    pte_t               held_pte;
    level_t             held_level;
    logic               held_fault;

    ptw_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_ptw_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_vaddr  (req_vaddr),
        .req_access (req_access),
        .req_full   (req_full),
        .satp_ppn   (satp_ppn),
        .flush      (flush),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_vaddr (resp_vaddr),
        .resp_pte   (resp_pte),
        .resp_level (resp_level),
        .resp_fault (resp_fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Pointer to the next table has v set and no permission bits
    function automatic bit is_pointer(pte_t p);
        return p.v && !p.r && !p.w && !p.x;
    endfunction

    // ##################################################
    // Memory model
    // ##################################################

    // Read latency and resp_ready both come from this one process
    initial begin
        logic [31:0] word_addr;
        int          lat;
        void'($urandom(32'h712a));
        word_addr = '0;
        lat       = 0;
        forever begin
            @(posedge clk);
            #1;
            resp_ready = ($urandom_range(0, 3) != 0);
            mem_rvalid = 1'b0;
            if (lat > 0) begin
                lat--;
                if (lat == 0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = mem.exists(word_addr) ? mem[word_addr] : '0;
                end
            end else if (rst && mem_rd) begin
                word_addr = mem_addr[PADDR_W-1:2];
                lat       = $urandom_range(1, 4);
            end
        end
    end

    // ##################################################
    // Monitors
    // ##################################################

    task automatic track_walk();
        logic [PADDR_W-1:0] exp_addr;
        if (mem_rd) begin
            if (expect_l0) begin
                exp_addr  = {next_ppn, cur_vaddr[OFFSET_W +: VPN_W], 2'b00};
                cur_level = LEVEL_0;
                expect_l0 = 1'b0;
            end else if (walk_q.size() == 0) begin
                $display("memory read issued with no request waiting at %0t", $time);
                errors++;
                exp_addr = mem_addr;
            end else begin
                cur_vaddr = walk_q.pop_front();
                exp_addr  = {satp_ppn, cur_vaddr[VADDR_W-1 -: VPN_W], 2'b00};
                cur_level = LEVEL_1;
            end
            checks++;
            assert (mem_addr == exp_addr) else begin
                $display("error %0t: mem_addr %h, expected %h", $time, mem_addr, exp_addr);
                errors++;
            end
            rd_count++;
            in_flight = 1'b1;
            aborted   = 1'b0;
        end
        if (mem_rvalid) begin
            in_flight = 1'b0;
            if (!aborted && !flush && cur_level == LEVEL_1 && is_pointer(mem_rdata)) begin
                expect_l0 = 1'b1;
                next_ppn  = mem_rdata.ppn;
            end
        end
        if (flush) begin
            if (in_flight) begin
                aborted = 1'b1;
            end
            walk_q.delete();
            expect_l0 = 1'b0;
        end
    endtask

    task automatic check_response();
        if (prev_hold) begin
            checks++;
            assert (resp_valid && resp_vaddr == held_vaddr && resp_pte == held_pte
                    && resp_level == held_level && resp_fault == held_fault) else begin
                $display("error %0t: response changed while waiting for resp_ready", $time);
                errors++;
            end
        end
        if (resp_valid && resp_ready) begin
            checks++;
            if (exp_vaddr.size() == 0) begin
                $display("response for vaddr %h arrived with none expected", resp_vaddr);
                errors++;
            end else begin
                assert (resp_vaddr == exp_vaddr[0] && resp_level == exp_level[0]
                        && resp_pte == exp_pte[0] && resp_fault == exp_fault[0]) else begin
                    $display("error %0t: response %h %0d %h %0d, want %h %0d %h %0d",
                             $time, resp_vaddr, resp_level, resp_pte, resp_fault,
                             exp_vaddr[0], exp_level[0], exp_pte[0], exp_fault[0]);
                    errors++;
                end
                void'(exp_vaddr.pop_front());
                void'(exp_level.pop_front());
                void'(exp_pte.pop_front());
                void'(exp_fault.pop_front());
            end
        end
        prev_hold  = resp_valid && !resp_ready;
        held_vaddr = resp_vaddr;
        held_pte   = resp_pte;
        held_level = resp_level;
        held_fault = resp_fault;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst) begin
                track_walk();
                check_response();
                if (req_full) begin
                    full_seen = 1'b1;
                end
            end
        end
    end

    // ##################################################
    // Stimulus tasks
    // ##################################################

    task automatic send_request(input logic [VADDR_W-1:0] vaddr, input access_t acc,
                                input level_t lvl, input pte_t pte, input logic fault,
                                input bit expect_resp);
        int n;
        n = 0;
        req_valid  = 1'b1;
        req_vaddr  = vaddr;
        req_access = acc;
        while (req_full && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (req_full) begin
            $display("timed out waiting for room in the request queue");
            errors++;
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            #1;
            walk_q.push_back(vaddr);
            if (expect_resp) begin
                exp_vaddr.push_back(vaddr);
                exp_level.push_back(lvl);
                exp_pte.push_back(pte);
                exp_fault.push_back(fault);
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_vaddr.size() != 0 || resp_valid) && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_vaddr.size() != 0 || resp_valid) begin
            $display("timed out waiting for %0d outstanding responses", exp_vaddr.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // Flush once the first walk of the group has read memory
    task automatic pulse_flush(input int start);
        int n;
        n = 0;
        while (rd_count <= start && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rd_count <= start) begin
            $display("timed out waiting for a walk to start before the flush");
            errors++;
            timed_out = 1'b1;
        end else begin
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
    endtask

    // ##################################################
    // Main sequence
    // ##################################################

    initial begin
        int          fd;
        int          code;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        int          acc;
        int          lvl;
        int          fault;
        int          flag;
        bit          in_group;
        int          group_start;

        rst        = 1'b0;
        req_valid  = 1'b0;
        req_vaddr  = '0;
        req_access = ACC_LOAD;
        satp_ppn   = '0;
        flush      = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        resp_ready = 1'b0;
        in_group   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;

        fd = $fopen("tests/ptw_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/ptw_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 3 || line.getc(0) == "#") begin
                    continue;
                end
                case (line.getc(0))
                    "M": begin
                        void'($sscanf(line.substr(2, line.len() - 1), "%h %h", a, d));
                        mem[a] = d;
                    end
                    "S": begin
                        drain();
                        void'($sscanf(line.substr(2, line.len() - 1), "%h", a));
                        satp_ppn = a[PPN_W-1:0];
                    end
                    "R": begin
                        void'($sscanf(line.substr(2, line.len() - 1), "%h %d %d %h %d %d",
                                      a, acc, lvl, d, fault, flag));
                        if (flag != 0 && !in_group) begin
                            drain();
                            group_start = rd_count;
                            in_group = 1'b1;
                        end else if (flag == 0 && in_group) begin
                            pulse_flush(group_start);
                            in_group = 1'b0;
                        end
                        if (!timed_out) begin
                            send_request(a, access_t'(acc[1:0]), level_t'(lvl[0]), pte_t'(d),
                                         fault[0], flag == 0);
                        end
                    end
                    default: begin
                        $display("unknown line in stimulus file: %s", line);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
            if (in_group && !timed_out) begin
                pulse_flush(group_start);
            end
            if (!timed_out) begin
                drain();
            end
            assert (full_seen) else begin
                $display("req_full never rose during the request bursts");
                errors++;
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ptw_top.f
design/ptw_pkg.sv
design/ptw_req_queue.sv
design/ptw_walker.sv
design/ptw_pte_check.sv
design/ptw_top.sv
tests/tb_ptw_top.sv

// File: Makefile
# Verilator build and run for the Sv32 page table walker

VERILATOR ?= verilator
TOP       ?= tb_ptw_top
FILELIST  ?= ptw_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/ptw_input.txt
# M word_addr data : memory word at physical address word_addr*4
# S ppn : root table page number; R vaddr access level pte fault flush_group
# access 0 load 1 store 2 fetch; flush_group 1 means flushed, no response
S 00100
# Root table, ppn 0x100
M 00040001 001000CF
M 00040002 00080001
M 00040004 002000C5
M 00040005 001004CF
M 00040006 00300043
# Level-0 table, ppn 0x200
M 00080003 048D14CF
M 00080005 000CCC01
M 00080006 00015447
M 00080007 0001980F
# Superpage leaf and two-level walk
R 00400abc 0 1 001000CF 0 0
R 00803010 2 0 048D14CF 0 0
# Fault rules, issued back to back so the queue fills
R 00C00000 0 1 00000000 1 0
R 01000000 1 1 002000C5 1 0
R 01400123 0 1 001004CF 1 0
R 01800000 1 1 00300043 1 0
R 01800000 2 1 00300043 1 0
R 01800000 0 1 00300043 0 0
R 00806000 1 0 00015447 1 0
R 00806000 0 0 00015447 0 0
R 00807000 0 0 0001980F 1 0
R 00805000 0 0 000CCC01 1 0
R 00804000 0 0 00000000 1 0
# Second burst, longer than the queue
R 00400004 2 1 001000CF 0 0
R 00803ff8 1 0 048D14CF 0 0
R 01800010 0 1 00300043 0 0
R 00806100 0 0 00015447 0 0
R 00400200 1 1 001000CF 0 0
R 00C00040 2 1 00000000 1 0
R 00803020 0 0 048D14CF 0 0
# Flushed group
R 00803010 0 0 048D14CF 0 1
R 00400000 1 1 001000CF 0 1
R 00806000 0 0 00015447 0 1
# After the flush
R 00400fff 2 1 001000CF 0 0
R 00803abc 1 0 048D14CF 0 0
